// File: all.f
+incdir+verif
hdl/fpmul_pkg.sv
hdl/fpmul_ifs.sv
hdl/fpmul_ctrl.sv
hdl/fp_unpack.sv
hdl/imul53.sv
hdl/fp_norm_pack.sv
hdl/fpmul_top.sv
verif/tb_fpmul.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_fpmul -f all.f -o sim_fpmul \
    && ./obj_dir/sim_fpmul > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^>>> PASS$" sim.log && echo "simulation ok" || { echo "simulation failed"; exit 1; }

// File: verif/fp_ref_model.svh
`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH

// expected binary64 product, truncated, tiny results flushed to signed zero
function automatic fpmul_pkg::fp64_t ref_mul(
    input  fpmul_pkg::fp64_t a,
    input  fpmul_pkg::fp64_t b,
    output logic             ovf,
    output logic             unf,
    output logic             inv
);
    logic         sign;
    logic         a_top, b_top, a_nan, b_nan, a_zero, b_zero, inf_zero;
    logic [127:0] prod;
    logic [127:0] aligned;
    int           ea, eb, lead, biased;
    sign     = a[63] ^ b[63];
    a_top    = &a[62:52];  // inf or nan
    b_top    = &b[62:52];
    a_nan    = a_top && (|a[51:0]);
    b_nan    = b_top && (|b[51:0]);
    a_zero   = (a[62:0] == 63'h0);
    b_zero   = (b[62:0] == 63'h0);
    inf_zero = (a_top && !a_nan && b_zero) || (b_top && !b_nan && a_zero);
    ovf      = 1'b0;
    unf      = 1'b0;
    inv      = inf_zero || (a_nan && !a[51]) || (b_nan && !b[51]);
    if (a_nan || b_nan || inf_zero) return fpmul_pkg::QNAN;
    if (a_top || b_top) return {sign, 11'h7ff, 52'h0};
    if (a_zero || b_zero) return {sign, 63'h0};
    // exponent field 0 means 2^-1022 without the hidden bit
    ea   = (a[62:52] == 11'h0) ? 1 : int'(a[62:52]);
    eb   = (b[62:52] == 11'h0) ? 1 : int'(b[62:52]);
    prod = {75'h0, (a[62:52] != 11'h0), a[51:0]} * {75'h0, (b[62:52] != 11'h0), b[51:0]};
    lead = 106;
    for (int i = 0; i < 106; i++) begin
        if (prod[i]) lead = 105 - i;  // highest set bit wins
    end
    // leading one weighs 2^(ea + eb - 2045 - lead), then add the bias
    biased = ea + eb - 1022 - lead;
    if (biased >= 2047) begin
        ovf = 1'b1;
        return {sign, 11'h7ff, 52'h0};
    end
    if (biased <= 0) begin
        unf = 1'b1;
        return {sign, 63'h0};
    end
    aligned = prod << lead;
    return {sign, biased[10:0], aligned[104:53]};  // bits under the leading one
endfunction

`endif

// File: verif/tb_fpmul.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fpmul;

    localparam int CLK_PERIOD    = 100;
    localparam int NUM_RANDOM    = 200;
    localparam int VALID_TIMEOUT = 40;
    // exact, random, subnormal, overflow, special, then both starts of the busy test
    localparam int NUM_OPS       = 3 + NUM_RANDOM + 5 + 2 + 9 + 2;

    logic             clk;
    logic             nrst;
    logic             start;
    fpmul_pkg::fp64_t op_a;
    fpmul_pkg::fp64_t op_b;
    fpmul_pkg::fp64_t result;
    logic             busy, valid, overflow, underflow, invalid;
    int               err_count;
    int               tests_passed;
    int               tests_failed;
    integer           seed;

    `include "fp_ref_model.svh"

    fpmul_top dut_i (
        .i_clk       (clk),
        .i_nrst      (nrst),
        .i_start     (start),
        .i_a         (op_a),
        .i_b         (op_b),
        .o_result    (result),
        .o_busy      (busy),
        .o_valid     (valid),
        .o_overflow  (overflow),
        .o_underflow (underflow),
        .o_invalid   (invalid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #((NUM_OPS * 25 + 50) * CLK_PERIOD);
        $display("error: run timed out after %0d cycles", NUM_OPS * 25 + 50);
        $display(">>> FAIL");
        $finish;
    end

    task automatic check_value(input string label, input string name,
                               input logic [63:0] got, input logic [63:0] expected);
        if (got !== expected) begin
            err_count++;
            $display("[FAIL] %s %s: got 0x%h, expected 0x%h", label, name, got, expected);
        end
    endtask

    // one operation, returns with o_valid high or after the timeout
    task automatic drive_op(input fpmul_pkg::fp64_t a, input fpmul_pkg::fp64_t b,
                            output logic done);
        int cycles;
        cycles = 0;
        @(negedge clk);
        op_a  = a;
        op_b  = b;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!valid && cycles < VALID_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        done = valid;
        if (!valid) begin
            err_count++;
            $display("error: o_valid did not come within %0d cycles", VALID_TIMEOUT);
        end
    endtask

    task automatic run_case(input string label, input fpmul_pkg::fp64_t a,
                            input fpmul_pkg::fp64_t b);
        fpmul_pkg::fp64_t exp_word;
        logic             exp_ovf, exp_unf, exp_inv;
        logic             done;
        exp_word = ref_mul(a, b, exp_ovf, exp_unf, exp_inv);
        drive_op(a, b, done);
        if (done) begin
            check_value(label, "o_result", result, exp_word);
            check_value(label, "o_overflow", 64'(overflow), 64'(exp_ovf));
            check_value(label, "o_underflow", 64'(underflow), 64'(exp_unf));
            check_value(label, "o_invalid", 64'(invalid), 64'(exp_inv));
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, err_count - errs_before);
        end
    endtask

    function automatic fpmul_pkg::fp64_t random_normal();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi[31], 11'd900 + {3'h0, hi[27:20]}, hi[19:0], lo};  // exponent 900..1155
    endfunction

    task automatic reset_state();
        int errs;
        errs = err_count;
        check_value("reset", "o_busy", 64'(busy), 64'h0);
        check_value("reset", "o_valid", 64'(valid), 64'h0);
        check_value("reset", "o_result", result, 64'h0);
        report_test("reset_state", errs);
    endtask

    task automatic exact_products();
        int errs;
        errs = err_count;
        run_case("1.5*2.0", 64'h3ff8_0000_0000_0000, 64'h4000_0000_0000_0000);
        check_value("1.5*2.0", "o_result", result, 64'h4008_0000_0000_0000);
        run_case("-3.0*0.25", 64'hc008_0000_0000_0000, 64'h3fd0_0000_0000_0000);
        check_value("-3.0*0.25", "o_result", result, 64'hbfe8_0000_0000_0000);
        run_case("7.0*-1.25", 64'h401c_0000_0000_0000, 64'hbff4_0000_0000_0000);
        check_value("7.0*-1.25", "o_result", result, 64'hc021_8000_0000_0000);
        report_test("exact_products", errs);
    endtask

    task automatic random_normals();
        int errs;
        errs = err_count;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            run_case($sformatf("random %0d", i), random_normal(), random_normal());
        end
        report_test("random_normals", errs);
    endtask

    task automatic subnormal_operands();
        int errs;
        errs = err_count;
        run_case("sub*4.0", 64'h0008_0000_0000_0000, 64'h4010_0000_0000_0000);
        run_case("minsub*2^1023", 64'h0000_0000_0000_0001, 64'h7fe0_0000_0000_0000);
        run_case("maxsub*1.5", 64'h000f_ffff_ffff_ffff, 64'h3ff8_0000_0000_0000);
        run_case("minnorm*0.5", 64'h0010_0000_0000_0000, 64'h3fe0_0000_0000_0000);
        run_case("sub*-sub", 64'h0000_0000_0000_0003, 64'h8000_0000_0000_0005);
        report_test("subnormal_operands", errs);
    endtask

    task automatic overflow_results();
        int errs;
        errs = err_count;
        run_case("2^1023*2.0", 64'h7fe0_0000_0000_0000, 64'h4000_0000_0000_0000);
        run_case("-1e300*1e300", 64'hfe37_e43c_8800_759c, 64'h7e37_e43c_8800_759c);
        report_test("overflow_results", errs);
    endtask

    task automatic special_operands();
        int errs;
        errs = err_count;
        run_case("0*3.0", 64'h0000_0000_0000_0000, 64'h4008_0000_0000_0000);
        run_case("-0*5.0", 64'h8000_0000_0000_0000, 64'h4014_0000_0000_0000);
        run_case("inf*2.0", 64'h7ff0_0000_0000_0000, 64'h4000_0000_0000_0000);
        run_case("3.0*-inf", 64'h4008_0000_0000_0000, 64'hfff0_0000_0000_0000);
        run_case("sub*inf", 64'h0000_0000_0000_0001, 64'h7ff0_0000_0000_0000);
        run_case("qnan*1.0", 64'h7ff8_0000_0000_0001, 64'h3ff0_0000_0000_0000);
        run_case("snan*1.0", 64'h7ff0_0000_0000_0001, 64'h3ff0_0000_0000_0000);
        run_case("inf*0", 64'h7ff0_0000_0000_0000, 64'h0000_0000_0000_0000);
        run_case("-0*-inf", 64'h8000_0000_0000_0000, 64'hfff0_0000_0000_0000);
        report_test("special_operands", errs);
    endtask

    // second start during multiply must leave no trace
    task automatic busy_start_ignored();
        int               errs;
        int               extra_valids;
        logic             done;
        fpmul_pkg::fp64_t exp_word;
        logic             exp_ovf, exp_unf, exp_inv;
        errs         = err_count;
        extra_valids = 0;
        exp_word     = ref_mul(64'h4008_0000_0000_0000, 64'h4014_0000_0000_0000,
                               exp_ovf, exp_unf, exp_inv);
        fork
            drive_op(64'h4008_0000_0000_0000, 64'h4014_0000_0000_0000, done);
            begin
                repeat (6) @(negedge clk);
                if (!busy) begin
                    err_count++;
                    $display("error: o_busy is low while an operation runs");
                end
                op_a  = 64'h4000_0000_0000_0000;
                op_b  = 64'h4000_0000_0000_0000;
                start = 1'b1;
                @(negedge clk);
                start = 1'b0;
            end
        join
        if (done) begin
            check_value("busy", "o_result", result, exp_word);
            check_value("busy", "o_overflow", 64'(overflow), 64'(exp_ovf));
            check_value("busy", "o_underflow", 64'(underflow), 64'(exp_unf));
            check_value("busy", "o_invalid", 64'(invalid), 64'(exp_inv));
        end
        repeat (25) begin
            @(negedge clk);
            if (valid) extra_valids++;
        end
        if (extra_valids != 0) begin
            err_count++;
            $display("error: the start given while busy produced another o_valid");
        end
        report_test("busy_start_ignored", errs);
    endtask

    initial begin
        clk          = 1'b0;
        nrst         = 1'b0;
        start        = 1'b0;
        op_a         = '0;
        op_b         = '0;
        err_count    = 0;
        tests_passed = 0;
        tests_failed = 0;
        seed         = 32'hb7d2_dd7a;
        repeat (8) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;
        reset_state();
        exact_products();
        random_normals();
        subnormal_operands();
        overflow_results();
        special_operands();
        busy_start_ignored();
        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : tb_fpmul

`default_nettype wire

// File: hdl/fpmul_top.sv
`timescale 1ns/1ps
`default_nettype none

module fpmul_top (
    input  wire logic              i_clk,
    input  wire logic              i_nrst,
    input  wire logic              i_start,
    input  wire fpmul_pkg::fp64_t  i_a,
    input  wire fpmul_pkg::fp64_t  i_b,
    output fpmul_pkg::fp64_t       o_result,
    output logic                   o_busy,
    output logic                   o_valid,
    output logic                   o_overflow,
    output logic                   o_underflow,
    output logic                   o_invalid
);

    logic load;
    logic pack_num;
    logic pack_spec;

    mul_if mul_bus ();
    op_if  op_bus ();

    fpmul_ctrl u_ctrl (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_start     (i_start),
        .i_op        (op_bus.ctl),
        .m           (mul_bus.ctrl),
        .o_load      (load),
        .o_pack_num  (pack_num),
        .o_pack_spec (pack_spec),
        .o_busy      (o_busy),
        .o_valid     (o_valid)
    );

    fp_unpack u_unpack (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .i_load (load),
        .i_a    (i_a),
        .i_b    (i_b),
        .m      (mul_bus.src),
        .o_op   (op_bus.drv)
    );

    imul53 u_mul (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .m      (mul_bus.unit)
    );

    fp_norm_pack u_pack (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_pack_num  (pack_num),
        .i_pack_spec (pack_spec),
        .m           (mul_bus.sink),
        .i_op        (op_bus.user),
        .o_result    (o_result),
        .o_overflow  (o_overflow),
        .o_underflow (o_underflow),
        .o_invalid   (o_invalid)
    );

endmodule : fpmul_top

`default_nettype wire

// File: hdl/fp_norm_pack.sv
`timescale 1ns/1ps
`default_nettype none

module fp_norm_pack (
    input  wire logic         i_clk,
    input  wire logic         i_nrst,
    input  wire logic         i_pack_num,
    input  wire logic         i_pack_spec,
    mul_if.sink               m,
    op_if.user                i_op,
    output fpmul_pkg::fp64_t  o_result,
    output logic              o_overflow,
    output logic              o_underflow,
    output logic              o_invalid
);

    fpmul_pkg::prod_t   shifted;
    fpmul_pkg::expsum_t exp_norm;
    fpmul_pkg::fp64_t   num_word;
    fpmul_pkg::fp64_t   spec_word;
    logic               num_ovf, num_unf;

    // leading one moved to bit 105
    assign shifted  = m.product << m.lead;
    assign exp_norm = i_op.exp_sum - fpmul_pkg::expsum_t'({6'h0, m.lead})
                    + fpmul_pkg::expsum_t'(1);

    always_comb begin
        num_ovf = 1'b0;
        num_unf = 1'b0;
        if (exp_norm >= fpmul_pkg::EXP_MAX) begin
            num_ovf  = 1'b1;
            num_word = {i_op.sign, 11'h7ff, 52'h0};
        end else if (exp_norm <= 0) begin
            num_unf  = 1'b1;  // flushed, no subnormal results
            num_word = {i_op.sign, 63'h0};
        end else begin
            num_word = {i_op.sign, exp_norm[10:0], shifted[104:53]};  // truncated
        end
    end

    always_comb begin
        case (i_op.spec)
            fpmul_pkg::SPEC_INF: spec_word = {i_op.sign, 11'h7ff, 52'h0};
            fpmul_pkg::SPEC_NAN: spec_word = fpmul_pkg::QNAN;
            default:             spec_word = {i_op.sign, 63'h0};
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_result    <= '0;
            o_overflow  <= 1'b0;
            o_underflow <= 1'b0;
            o_invalid   <= 1'b0;
        end else if (i_pack_num) begin
            o_result    <= num_word;
            o_overflow  <= num_ovf;
            o_underflow <= num_unf;
            o_invalid   <= 1'b0;
        end else if (i_pack_spec) begin
            o_result    <= spec_word;
            o_overflow  <= 1'b0;
            o_underflow <= 1'b0;
            o_invalid   <= i_op.invalid;
        end
    end

endmodule : fp_norm_pack

`default_nettype wire

// File: hdl/imul53.sv
`timescale 1ns/1ps
`default_nettype none

module imul53 (
    input  wire logic  i_clk,
    input  wire logic  i_nrst,
    mul_if.unit        m
);

    logic [56:0]       mult_tbl [16];  // a * 0 .. a * 15
    logic [56:0]       a_x16;
    logic [56:0]       sel;
    fpmul_pkg::mant_t  a_r;
    logic [55:0]       b_r;            // b padded to 14 nibbles
    fpmul_pkg::prod_t  sum_r;
    fpmul_pkg::lead_t  lead_r;
    fpmul_pkg::lead_t  lead_c;
    fpmul_pkg::lead_t  lz_hi, lz_lo;
    logic              hi_found, lo_found;
    logic [fpmul_pkg::MUL_DELAY-1:0] delay_r;
    logic              accum_ena_r;

    // multiples built from shifts and one add or subtract each
    always_comb begin
        a_x16        = {a_r, 4'h0};
        mult_tbl[0]  = '0;
        mult_tbl[1]  = {4'h0, a_r};
        mult_tbl[2]  = {3'h0, a_r, 1'b0};
        mult_tbl[3]  = mult_tbl[2] + mult_tbl[1];
        mult_tbl[4]  = {2'h0, a_r, 2'h0};
        mult_tbl[5]  = mult_tbl[4] + mult_tbl[1];
        mult_tbl[6]  = mult_tbl[4] + mult_tbl[2];
        mult_tbl[8]  = {1'b0, a_r, 3'h0};
        mult_tbl[7]  = mult_tbl[8] - mult_tbl[1];
        mult_tbl[9]  = mult_tbl[8] + mult_tbl[1];
        mult_tbl[10] = mult_tbl[8] + mult_tbl[2];
        mult_tbl[11] = mult_tbl[10] + mult_tbl[1];
        mult_tbl[12] = mult_tbl[8] + mult_tbl[4];
        mult_tbl[13] = a_x16 - mult_tbl[3];
        mult_tbl[14] = a_x16 - mult_tbl[2];
        mult_tbl[15] = a_x16 - mult_tbl[1];
    end

    assign sel = mult_tbl[b_r[55:52]];  // top nibble of b picks the multiple

    // leading one search split in two halves to keep the path short
    always_comb begin
        lz_hi    = '0;
        lz_lo    = '0;
        hi_found = 1'b0;
        lo_found = 1'b0;
        for (int i = 0; i < 64; i++) begin
            if (!hi_found && sum_r[105-i]) begin
                lz_hi    = fpmul_pkg::lead_t'(i);
                hi_found = 1'b1;
            end
        end
        for (int i = 0; i < 42; i++) begin
            if (!lo_found && sum_r[41-i]) begin
                lz_lo    = fpmul_pkg::lead_t'(i);
                lo_found = 1'b1;
            end
        end
        lead_c = hi_found ? lz_hi : (7'd64 + lz_lo);
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            a_r         <= '0;
            b_r         <= '0;
            sum_r       <= '0;
            lead_r      <= '0;
            delay_r     <= '0;
            accum_ena_r <= 1'b0;
        end else begin
            delay_r <= {delay_r[fpmul_pkg::MUL_DELAY-2:0], m.ena};
            if (m.ena) begin
                a_r         <= m.a;
                b_r         <= {3'h0, m.b};
                sum_r       <= '0;
                lead_r      <= '0;
                accum_ena_r <= 1'b1;
            end else begin
                if (accum_ena_r) begin
                    sum_r <= {sum_r[101:0], 4'h0} + {49'h0, sel};  // shift by a nibble and add
                    b_r   <= {b_r[51:0], 4'h0};
                end
                if (delay_r[fpmul_pkg::MUL_STEPS-1]) accum_ena_r <= 1'b0;  // after 14 steps
                if (delay_r[fpmul_pkg::MUL_DELAY-2]) lead_r <= lead_c;     // sum is final here
            end
        end
    end

    assign m.product = sum_r;
    assign m.lead    = lead_r;
    assign m.rdy     = delay_r[fpmul_pkg::MUL_DELAY-1];

endmodule : imul53

`default_nettype wire

// File: hdl/fp_unpack.sv
`timescale 1ns/1ps
`default_nettype none

module fp_unpack (
    input  wire logic              i_clk,
    input  wire logic              i_nrst,
    input  wire logic              i_load,
    input  wire fpmul_pkg::fp64_t  i_a,
    input  wire fpmul_pkg::fp64_t  i_b,
    mul_if.src                     m,
    op_if.drv                      o_op
);

    fpmul_pkg::fp64_t  opr_r [2];
    fpmul_pkg::mant_t  mant [2];
    logic [10:0]       exp_eff [2];
    logic [1:0]        is_nan, is_snan, is_inf, is_zero;
    logic              inf_zero;
    fpmul_pkg::spec_t  spec_c;
    logic              invalid_c;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            opr_r[0] <= '0;
            opr_r[1] <= '0;
        end else if (i_load) begin
            opr_r[0] <= i_a;
            opr_r[1] <= i_b;
        end
    end

    // per-operand fields
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            is_nan[i]  = (&opr_r[i][62:52]) && (|opr_r[i][51:0]);
            is_snan[i] = is_nan[i] && !opr_r[i][51];  // quiet bit clear
            is_inf[i]  = (&opr_r[i][62:52]) && !(|opr_r[i][51:0]);
            is_zero[i] = !(|opr_r[i][62:0]);
            // subnormal: no hidden bit, exponent taken as 1
            mant[i]    = {|opr_r[i][62:52], opr_r[i][51:0]};
            exp_eff[i] = (|opr_r[i][62:52]) ? opr_r[i][62:52] : 11'd1;
        end
    end

    assign inf_zero = (is_inf[0] && is_zero[1]) || (is_zero[0] && is_inf[1]);

    always_comb begin
        invalid_c = 1'b0;
        if ((|is_nan) || inf_zero) begin
            spec_c    = fpmul_pkg::SPEC_NAN;
            invalid_c = inf_zero || (|is_snan);
        end else if (|is_inf) begin
            spec_c = fpmul_pkg::SPEC_INF;
        end else if (|is_zero) begin
            spec_c = fpmul_pkg::SPEC_ZERO;
        end else begin
            spec_c = fpmul_pkg::SPEC_NONE;
        end
    end

    assign m.a = mant[0];
    assign m.b = mant[1];

    // biased exponent when the product's leading one sits at bit 104
    assign o_op.exp_sum = fpmul_pkg::expsum_t'({2'b00, exp_eff[0]})
                        + fpmul_pkg::expsum_t'({2'b00, exp_eff[1]})
                        - fpmul_pkg::expsum_t'(fpmul_pkg::EXP_BIAS);
    assign o_op.sign    = opr_r[0][63] ^ opr_r[1][63];
    assign o_op.spec    = spec_c;
    assign o_op.invalid = invalid_c;

endmodule : fp_unpack

`default_nettype wire

// File: hdl/fpmul_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fpmul_ctrl (
    input  wire logic  i_clk,
    input  wire logic  i_nrst,
    input  wire logic  i_start,
    op_if.ctl          i_op,
    mul_if.ctrl        m,
    output logic       o_load,
    output logic       o_pack_num,
    output logic       o_pack_spec,
    output logic       o_busy,
    output logic       o_valid
);

    fpmul_pkg::ctrl_state_t state, state_nxt;
    logic special_r;  // result comes from the class code, multiplier skipped
    logic ena_r;

    always_comb begin
        state_nxt = state;
        case (state)
            fpmul_pkg::IDLE: begin
                if (i_start) state_nxt = fpmul_pkg::CLASSIFY;
            end
            fpmul_pkg::CLASSIFY: begin
                if (i_op.spec == fpmul_pkg::SPEC_NONE) state_nxt = fpmul_pkg::MULTIPLY;
                else state_nxt = fpmul_pkg::PACK;
            end
            fpmul_pkg::MULTIPLY: begin
                if (m.rdy) state_nxt = fpmul_pkg::PACK;
            end
            fpmul_pkg::PACK:     state_nxt = fpmul_pkg::DONE;
            default:             state_nxt = fpmul_pkg::IDLE;  // DONE
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state     <= fpmul_pkg::IDLE;
            special_r <= 1'b0;
            ena_r     <= 1'b0;
        end else begin
            state <= state_nxt;
            ena_r <= (state == fpmul_pkg::CLASSIFY) && (i_op.spec == fpmul_pkg::SPEC_NONE);
            if (state == fpmul_pkg::CLASSIFY) begin
                special_r <= (i_op.spec != fpmul_pkg::SPEC_NONE);
            end
        end
    end

    assign m.ena       = ena_r;  // one cycle after classify
    assign o_load      = (state == fpmul_pkg::IDLE) && i_start;  // starts elsewhere are dropped
    assign o_pack_num  = (state == fpmul_pkg::PACK) && !special_r;
    assign o_pack_spec = (state == fpmul_pkg::PACK) && special_r;
    assign o_valid     = (state == fpmul_pkg::DONE);
    assign o_busy      = (state != fpmul_pkg::IDLE);

endmodule : fpmul_ctrl

`default_nettype wire

// File: hdl/fpmul_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// mantissa multiplier bus
interface mul_if;
    logic              ena;      // start pulse from the fsm
    fpmul_pkg::mant_t  a;
    fpmul_pkg::mant_t  b;
    fpmul_pkg::prod_t  product;
    fpmul_pkg::lead_t  lead;
    logic              rdy;      // product and lead valid

    modport ctrl (output ena, input rdy);
    modport src  (output a, b);
    modport unit (input ena, a, b, output product, lead, rdy);
    modport sink (input product, lead);
endinterface : mul_if

// operand class and exponent from the unpack stage
interface op_if;
    logic                sign;
    fpmul_pkg::expsum_t  exp_sum;
    fpmul_pkg::spec_t    spec;
    logic                invalid;

    modport drv  (output sign, exp_sum, spec, invalid);
    modport ctl  (input spec);
    modport user (input sign, exp_sum, spec, invalid);
endinterface : op_if

`default_nettype wire

// File: hdl/fpmul_pkg.sv
`default_nettype none

package fpmul_pkg;

    typedef logic [63:0]         fp64_t;    // binary64 word
    typedef logic [52:0]         mant_t;    // hidden bit + fraction
    typedef logic [105:0]        prod_t;    // full mantissa product
    typedef logic [6:0]          lead_t;    // leading zeros of a product
    typedef logic signed [12:0]  expsum_t;  // exponent before normalization
    typedef logic [1:0]          spec_t;    // special result class

    // sequencing of one operation
    typedef enum logic [2:0] {
        IDLE,
        CLASSIFY,
        MULTIPLY,
        PACK,
        DONE
    } ctrl_state_t;

    localparam int EXP_BIAS = 1023;
    localparam int EXP_MAX  = 2047;

    localparam fp64_t QNAN = 64'h7ff8_0000_0000_0000;  // canonical quiet nan

    localparam int MUL_STEPS = 14;  // nibbles of the padded 56-bit b
    localparam int MUL_DELAY = 16;  // ena to rdy

    localparam spec_t SPEC_NONE = 2'd0;
    localparam spec_t SPEC_ZERO = 2'd1;
    localparam spec_t SPEC_INF  = 2'd2;
    localparam spec_t SPEC_NAN  = 2'd3;

endpackage : fpmul_pkg

`default_nettype wire
